/* rtl/issue_pkg.sv */
// --------------------------------------
// Shared sizes and types for the issue stage
// Referenced by scoped name from every block
// --------------------------------------
package issue_pkg;

    // Datapath and table sizes
    localparam int XLEN          = 32;
    localparam int NR_SB_ENTRIES = 4;
    localparam int TRANS_ID_BITS = 2;
    localparam int REG_ADDR_BITS = 5;
    localparam int OP_BITS       = 4;

    // Target functional unit
    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_LSU
    } fu_t;

    // One in-flight instruction, trans_id and result filled by the scoreboard
    typedef struct packed {
        fu_t                      fu;
        logic [OP_BITS-1:0]       op;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs1;
        logic [REG_ADDR_BITS-1:0] rs2;
        logic                     use_imm;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
    } scoreboard_entry_t;

    // Operands handed to the ALU or LSU
    typedef struct packed {
        fu_t                      fu;
        logic [OP_BITS-1:0]       op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // Oldest finished instruction offered to commit
    typedef struct packed {
        logic [REG_ADDR_BITS-1:0] rd;
        logic [XLEN-1:0]          result;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } commit_t;

endpackage

/* rtl/sb_iro_if.sv */
// --------------------------------------
// Link between scoreboard and operand read
// Scoreboard drives the sb side, issue_read_operands the iro side
// --------------------------------------
`timescale 1ns/1ps

interface sb_iro_if;

    // Instruction waiting at the head of decode
    issue_pkg::scoreboard_entry_t issue_instr;
    logic                         issue_valid;
    logic                         issue_ack;

    // Table state used for hazard checks and forwarding
    logic [issue_pkg::TRANS_ID_BITS-1:0]                         issue_pointer;
    logic                                                        full;
    logic [issue_pkg::NR_SB_ENTRIES-1:0]                         still_issued;
    logic [issue_pkg::NR_SB_ENTRIES-1:0]                         result_valid;
    issue_pkg::scoreboard_entry_t [issue_pkg::NR_SB_ENTRIES-1:0] entries;

    modport sb (
        output issue_instr, issue_valid, issue_pointer, full,
        output still_issued, result_valid, entries,
        input  issue_ack
    );

    modport iro (
        input  issue_instr, issue_valid, issue_pointer, full,
        input  still_issued, result_valid, entries,
        output issue_ack
    );

endinterface

/* rtl/scoreboard.sv */
// --------------------------------------
// Circular table of in-flight instructions
// Allocates on issue ack, collects writebacks by ID, retires in order
// --------------------------------------
`timescale 1ns/1ps

module scoreboard (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    // Decode side
    input  issue_pkg::scoreboard_entry_t        decoded_instr_i,
    input  logic                                decoded_instr_valid_i,
    // Writeback from the functional units
    input  logic                                wt_valid_i,
    input  logic [issue_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [issue_pkg::XLEN-1:0]          wbdata_i,
    // Commit side
    output issue_pkg::commit_t                  commit_instr_o,
    output logic                                commit_valid_o,
    input  logic                                commit_ack_i,
    output logic                                sb_full_o,
    sb_iro_if.sb                                sb
);

    // Slot payloads
    issue_pkg::scoreboard_entry_t [issue_pkg::NR_SB_ENTRIES-1:0] mem_q;

    // Per-slot state and ring pointers
    logic [issue_pkg::NR_SB_ENTRIES-1:0] busy_q;
    logic [issue_pkg::NR_SB_ENTRIES-1:0] done_q;
    logic [issue_pkg::TRANS_ID_BITS-1:0] issue_ptr_q;
    logic [issue_pkg::TRANS_ID_BITS-1:0] commit_ptr_q;

    logic alloc;
    logic retire;

    // Decode view, nothing is offered while the table is being flushed
    assign sb.issue_instr = decoded_instr_i;
    assign sb.issue_valid = decoded_instr_valid_i & ~flush_i;

    assign alloc  = sb.issue_valid & sb.issue_ack;
    assign retire = commit_valid_o & commit_ack_i;

    // --------------------------------------
    // Control state
    // --------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q       <= '0;
            done_q       <= '0;
            issue_ptr_q  <= '0;
            commit_ptr_q <= '0;
        end else begin
            // New instruction takes the slot under the issue pointer
            if (alloc) begin
                busy_q[issue_ptr_q] <= 1'b1;
                done_q[issue_ptr_q] <= 1'b0;
                issue_ptr_q         <= issue_ptr_q + 1'b1;
            end
            // Result is visible from the following cycle
            if (wt_valid_i) begin
                done_q[trans_id_i] <= 1'b1;
            end
            // Oldest slot leaves on commit ack
            if (retire) begin
                busy_q[commit_ptr_q] <= 1'b0;
                commit_ptr_q         <= commit_ptr_q + 1'b1;
            end
            // Drop everything in flight
            // Commit pointer follows issue pointer so the empty ring lines up again
            if (flush_i) begin
                busy_q       <= '0;
                commit_ptr_q <= issue_ptr_q;
            end
        end
    end

    // --------------------------------------
    // Slot payloads
    // --------------------------------------
    always_ff @(posedge clk_i) begin
        if (alloc) begin
            mem_q[issue_ptr_q]          <= decoded_instr_i;
            mem_q[issue_ptr_q].trans_id <= issue_ptr_q;
            mem_q[issue_ptr_q].result   <= '0;
        end
        if (wt_valid_i) begin
            mem_q[trans_id_i].result <= wbdata_i;
        end
    end

    // Table state towards operand read
    assign sb.issue_pointer = issue_ptr_q;
    assign sb.full          = &busy_q;
    assign sb.still_issued  = busy_q;
    assign sb.result_valid  = done_q;
    assign sb.entries       = mem_q;

    // Ring is full once every slot is busy
    assign sb_full_o = &busy_q;

    // In-order commit from the commit pointer
    assign commit_valid_o = busy_q[commit_ptr_q] & done_q[commit_ptr_q];
    assign commit_instr_o = '{
        rd:       mem_q[commit_ptr_q].rd,
        result:   mem_q[commit_ptr_q].result,
        trans_id: mem_q[commit_ptr_q].trans_id
    };

endmodule

/* rtl/regfile.sv */
// --------------------------------------
// Integer register file, 2 read ports and 1 write port
// Reads are combinational, writes land at the clock edge
// --------------------------------------
`timescale 1ns/1ps

module regfile (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] raddr_a_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] raddr_b_i,
    output logic [issue_pkg::XLEN-1:0]          rdata_a_o,
    output logic [issue_pkg::XLEN-1:0]          rdata_b_o,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] waddr_i,
    input  logic [issue_pkg::XLEN-1:0]          wdata_i,
    input  logic                                we_i
);

    logic [issue_pkg::XLEN-1:0] regs_q [2**issue_pkg::REG_ADDR_BITS];

    // Flop array, x0 never takes a write
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**issue_pkg::REG_ADDR_BITS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // x0 reads zero
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* rtl/issue_read_operands.sv */
// --------------------------------------
// Hazard check, operand selection and dispatch
// Acks decode combinationally, drives the units one cycle later
// --------------------------------------
`timescale 1ns/1ps

module issue_read_operands (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    sb_iro_if.iro                               iro,
    // Register file read port
    input  logic [issue_pkg::XLEN-1:0]          rs1_data_i,
    input  logic [issue_pkg::XLEN-1:0]          rs2_data_i,
    output logic [issue_pkg::REG_ADDR_BITS-1:0] rs1_addr_o,
    output logic [issue_pkg::REG_ADDR_BITS-1:0] rs2_addr_o,
    // Functional units
    input  logic                                alu_ready_i,
    input  logic                                lsu_ready_i,
    output logic                                alu_valid_o,
    output logic                                lsu_valid_o,
    output issue_pkg::fu_data_t                 fu_data_o,
    output logic                                stall_issue_o
);

    logic [issue_pkg::TRANS_ID_BITS-1:0] scan_idx;
    logic [issue_pkg::TRANS_ID_BITS-1:0] rs1_slot;
    logic [issue_pkg::TRANS_ID_BITS-1:0] rs2_slot;
    logic                                rs1_hit;
    logic                                rs2_hit;
    logic                                raw_stall;
    logic                                fu_ready;
    logic [issue_pkg::XLEN-1:0]          operand_a;
    logic [issue_pkg::XLEN-1:0]          operand_b;
    logic                                alu_valid_q;
    logic                                lsu_valid_q;
    issue_pkg::fu_data_t                 fu_data_q;

    assign rs1_addr_o = iro.issue_instr.rs1;
    assign rs2_addr_o = iro.issue_instr.rs2;

    // --------------------------------------
    // Producer search
    // --------------------------------------
    // Walk back from the newest slot, first busy writer of the source wins
    always_comb begin
        rs1_hit  = 1'b0;
        rs2_hit  = 1'b0;
        rs1_slot = '0;
        rs2_slot = '0;
        scan_idx = '0;
        for (int i = 1; i <= issue_pkg::NR_SB_ENTRIES; i++) begin
            scan_idx = iro.issue_pointer - (issue_pkg::TRANS_ID_BITS)'(i);
            if (!rs1_hit && iro.still_issued[scan_idx] && iro.issue_instr.rs1 != '0
                    && iro.entries[scan_idx].rd == iro.issue_instr.rs1) begin
                rs1_hit  = 1'b1;
                rs1_slot = scan_idx;
            end
            if (!rs2_hit && iro.still_issued[scan_idx] && iro.issue_instr.rs2 != '0
                    && iro.entries[scan_idx].rd == iro.issue_instr.rs2) begin
                rs2_hit  = 1'b1;
                rs2_slot = scan_idx;
            end
        end
    end

    // Stall while a producer has no result yet
    // rs2 only matters when it is really read
    assign raw_stall = (rs1_hit & ~iro.result_valid[rs1_slot])
                     | (rs2_hit & ~iro.result_valid[rs2_slot] & ~iro.issue_instr.use_imm);

    // Forward a finished result, else take the register value
    assign operand_a = rs1_hit ? iro.entries[rs1_slot].result : rs1_data_i;
    assign operand_b = iro.issue_instr.use_imm ? iro.issue_instr.imm
                     : rs2_hit ? iro.entries[rs2_slot].result : rs2_data_i;

    // Ready of the selected unit, no unit means nothing to wait for
    always_comb begin
        case (iro.issue_instr.fu)
            issue_pkg::FU_ALU: fu_ready = alu_ready_i;
            issue_pkg::FU_LSU: fu_ready = lsu_ready_i;
            default:           fu_ready = 1'b1;
        endcase
    end

    assign iro.issue_ack = iro.issue_valid & ~flush_i & ~iro.full & fu_ready & ~raw_stall;
    assign stall_issue_o = iro.issue_valid & ~iro.issue_ack;

    // --------------------------------------
    // Dispatch register
    // --------------------------------------
    // Valids pulse for exactly one cycle per accepted instruction
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            alu_valid_q <= 1'b0;
            lsu_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= iro.issue_ack & (iro.issue_instr.fu == issue_pkg::FU_ALU);
            lsu_valid_q <= iro.issue_ack & (iro.issue_instr.fu == issue_pkg::FU_LSU);
        end
    end

    // Operands hold between pulses, trans_id is the slot just taken
    always_ff @(posedge clk_i) begin
        if (iro.issue_ack) begin
            fu_data_q <= '{
                fu:        iro.issue_instr.fu,
                op:        iro.issue_instr.op,
                operand_a: operand_a,
                operand_b: operand_b,
                trans_id:  iro.issue_pointer
            };
        end
    end

    assign alu_valid_o = alu_valid_q;
    assign lsu_valid_o = lsu_valid_q;
    assign fu_data_o   = fu_data_q;

endmodule

/* rtl/issue_stage.sv */
// --------------------------------------
// Issue stage top level
// Scoreboard, operand read and register file behind plain ports
// --------------------------------------
`timescale 1ns/1ps

module issue_stage (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                flush_unissued_instr_i,
    // Decode handshake
    input  issue_pkg::scoreboard_entry_t        decoded_instr_i,
    input  logic                                decoded_instr_valid_i,
    output logic                                decoded_instr_ack_o,
    // Functional units
    input  logic                                alu_ready_i,
    input  logic                                lsu_ready_i,
    output logic                                alu_valid_o,
    output logic                                lsu_valid_o,
    output issue_pkg::fu_data_t                 fu_data_o,
    // Writeback
    input  logic                                wt_valid_i,
    input  logic [issue_pkg::TRANS_ID_BITS-1:0] trans_id_i,
    input  logic [issue_pkg::XLEN-1:0]          wbdata_i,
    // Commit and register file write
    output issue_pkg::commit_t                  commit_instr_o,
    output logic                                commit_valid_o,
    input  logic                                commit_ack_i,
    input  logic                                we_i,
    input  logic [issue_pkg::REG_ADDR_BITS-1:0] waddr_i,
    input  logic [issue_pkg::XLEN-1:0]          wdata_i,
    // Status
    output logic                                sb_full_o,
    output logic                                stall_issue_o
);

    // Register file read path
    logic [issue_pkg::REG_ADDR_BITS-1:0] rs1_addr;
    logic [issue_pkg::REG_ADDR_BITS-1:0] rs2_addr;
    logic [issue_pkg::XLEN-1:0]          rs1_data;
    logic [issue_pkg::XLEN-1:0]          rs2_data;

    sb_iro_if sb_iro ();

    // Decode sees the operand-read acknowledge directly
    assign decoded_instr_ack_o = sb_iro.issue_ack;

    // --------------------------------------
    // Instruction tracking
    // --------------------------------------
    scoreboard i_scoreboard (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .flush_i               (flush_i),
        .decoded_instr_i       (decoded_instr_i),
        .decoded_instr_valid_i (decoded_instr_valid_i),
        .wt_valid_i            (wt_valid_i),
        .trans_id_i            (trans_id_i),
        .wbdata_i              (wbdata_i),
        .commit_instr_o        (commit_instr_o),
        .commit_valid_o        (commit_valid_o),
        .commit_ack_i          (commit_ack_i),
        .sb_full_o             (sb_full_o),
        .sb                    (sb_iro.sb)
    );

    // Unissued flush only blocks the acknowledge
    issue_read_operands i_issue_read_operands (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .flush_i       (flush_unissued_instr_i),
        .iro           (sb_iro.iro),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .alu_ready_i   (alu_ready_i),
        .lsu_ready_i   (lsu_ready_i),
        .alu_valid_o   (alu_valid_o),
        .lsu_valid_o   (lsu_valid_o),
        .fu_data_o     (fu_data_o),
        .stall_issue_o (stall_issue_o)
    );

    regfile i_regfile (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .raddr_a_i (rs1_addr),
        .raddr_b_i (rs2_addr),
        .rdata_a_o (rs1_data),
        .rdata_b_o (rs2_data),
        .waddr_i   (waddr_i),
        .wdata_i   (wdata_i),
        .we_i      (we_i)
    );

endmodule

/* verif/issue_stage_tb.sv */
// --------------------------------------
// Self-checking testbench for the issue stage
// Applies a table of actions and checks against a scoreboard model
// --------------------------------------
`timescale 1ns/1ps

module issue_stage_tb;

    typedef enum logic [2:0] {WRITE_REG, ISSUE, ISSUE_FLUSHED, WRITEBACK, COMMIT, FLUSH} act_t;

    // exp holds the expected ack on issue rows and commit_valid_o on commit rows
    // aux holds lsu_ready_i on issue rows and the transaction ID on writeback rows
    typedef struct packed {
        act_t                act;
        issue_pkg::fu_t      fu;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [31:0]         imm;
        logic                exp;
        logic [1:0]          aux;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_n_i, flush_i, flush_unissued_instr_i, decoded_instr_valid_i, decoded_instr_ack_o;
    logic alu_ready_i, lsu_ready_i, alu_valid_o, lsu_valid_o, wt_valid_i;
    logic commit_valid_o, commit_ack_i, we_i, sb_full_o, stall_issue_o;
    logic [1:0]  trans_id_i;
    logic [4:0]  waddr_i;
    logic [31:0] wbdata_i, wdata_i;
    issue_pkg::scoreboard_entry_t decoded_instr_i;
    issue_pkg::fu_data_t          fu_data_o;
    issue_pkg::commit_t           commit_instr_o;

    // Model of the register file and the scoreboard ring
    logic [31:0] m_regs [32];
    logic [31:0] m_res [4];
    logic [4:0]  m_rd [4];
    logic [3:0]  m_busy;
    logic [1:0]  m_iptr, m_cptr;

    row_t        rows [$];
    logic [31:0] seed = 32'h26d1dda2;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit = 0;

    issue_stage UUT (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .flush_unissued_instr_i(flush_unissued_instr_i),
        .decoded_instr_i(decoded_instr_i), .decoded_instr_valid_i(decoded_instr_valid_i),
        .decoded_instr_ack_o(decoded_instr_ack_o),
        .alu_ready_i(alu_ready_i), .lsu_ready_i(lsu_ready_i),
        .alu_valid_o(alu_valid_o), .lsu_valid_o(lsu_valid_o), .fu_data_o(fu_data_o),
        .wt_valid_i(wt_valid_i), .trans_id_i(trans_id_i), .wbdata_i(wbdata_i),
        .commit_instr_o(commit_instr_o), .commit_valid_o(commit_valid_o),
        .commit_ack_i(commit_ack_i), .we_i(we_i), .waddr_i(waddr_i), .wdata_i(wdata_i),
        .sb_full_o(sb_full_o), .stall_issue_o(stall_issue_o)
    );

    always #10 clk_i = ~clk_i;

    // Run limit scales with the table
    always @(posedge clk_i) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Youngest busy writer of rs supplies the value, else the register
    function automatic logic [31:0] src_value(input logic [4:0] rs);
        logic [1:0] idx;
        if (rs == 5'd0) return 32'd0;
        for (int i = 1; i <= 4; i++) begin
            idx = m_iptr - i;
            if (m_busy[idx] && m_rd[idx] == rs) return m_res[idx];
        end
        return m_regs[rs];
    endfunction

    task automatic add_row(input act_t act, input issue_pkg::fu_t fu, input int rd, input int rs1,
                           input int rs2, input logic [31:0] imm, input bit exp, input int aux);
        row_t r;
        r = '{act, fu, rd[4:0], rs1[4:0], rs2[4:0], imm, exp, aux[1:0]};
        rows.push_back(r);
    endtask

    task automatic apply_row(input int n);
        row_t        r;
        logic [31:0] val;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        int          errs_before;
        bit          is_issue;
        r = rows[n];
        errs_before = errors;
        is_issue = (r.act == ISSUE || r.act == ISSUE_FLUSHED);
        @(posedge clk_i);
        #2;
        case (r.act)
            WRITE_REG: begin
                val = next_rand();
                we_i = 1'b1;
                waddr_i = r.rd;
                wdata_i = val;
            end
            ISSUE, ISSUE_FLUSHED: begin
                decoded_instr_i = '0;
                decoded_instr_i.fu = r.fu;
                decoded_instr_i.op = r.rd[3:0];
                decoded_instr_i.rd = r.rd;
                decoded_instr_i.rs1 = r.rs1;
                decoded_instr_i.rs2 = r.rs2;
                decoded_instr_i.use_imm = (r.imm != 0);
                decoded_instr_i.imm = r.imm;
                decoded_instr_valid_i = 1'b1;
                lsu_ready_i = r.aux[0];
                flush_unissued_instr_i = (r.act == ISSUE_FLUSHED);
                exp_a = src_value(r.rs1);
                exp_b = (r.imm != 0) ? r.imm : src_value(r.rs2);
            end
            WRITEBACK: begin
                val = next_rand();
                wt_valid_i = 1'b1;
                trans_id_i = r.aux;
                wbdata_i = val;
            end
            // Commit stage writes the register file as it acknowledges
            COMMIT: begin
                commit_ack_i = r.exp;
                we_i = r.exp;
                waddr_i = m_rd[m_cptr];
                wdata_i = m_res[m_cptr];
            end
            default: flush_i = 1'b1;
        endcase
        #5;
        check_equal("sb_full_o", sb_full_o, &m_busy);
        check_equal("alu_valid_o between pulses", alu_valid_o, 0);
        check_equal("lsu_valid_o between pulses", lsu_valid_o, 0);
        check_equal("decoded_instr_ack_o", decoded_instr_ack_o, is_issue ? r.exp : 1'b0);
        if (is_issue) check_equal("stall_issue_o", stall_issue_o, !r.exp);
        if (r.act == COMMIT) begin
            check_equal("commit_valid_o", commit_valid_o, r.exp);
            if (r.exp) begin
                check_equal("commit rd", commit_instr_o.rd, m_rd[m_cptr]);
                check_equal("commit result", commit_instr_o.result, m_res[m_cptr]);
                check_equal("commit trans_id", commit_instr_o.trans_id, m_cptr);
            end
        end
        @(posedge clk_i);
        #2;
        // Dispatch shows exactly one cycle after the accepting edge
        if (is_issue) begin
            check_equal("alu_valid_o", alu_valid_o, r.exp && r.fu == issue_pkg::FU_ALU);
            check_equal("lsu_valid_o", lsu_valid_o, r.exp && r.fu == issue_pkg::FU_LSU);
            if (r.exp) begin
                check_equal("fu_data fu", fu_data_o.fu, r.fu);
                check_equal("fu_data op", fu_data_o.op, r.rd[3:0]);
                check_equal("fu_data operand_a", fu_data_o.operand_a, exp_a);
                check_equal("fu_data operand_b", fu_data_o.operand_b, exp_b);
                check_equal("fu_data trans_id", fu_data_o.trans_id, m_iptr);
                m_busy[m_iptr] = 1'b1;
                m_rd[m_iptr] = r.rd;
                m_res[m_iptr] = '0;
                m_iptr++;
            end
        end
        case (r.act)
            WRITE_REG: if (r.rd != 0) m_regs[r.rd] = val;
            WRITEBACK: m_res[r.aux] = val;
            COMMIT: if (r.exp) begin
                if (m_rd[m_cptr] != 0) m_regs[m_rd[m_cptr]] = m_res[m_cptr];
                m_busy[m_cptr] = 1'b0;
                m_cptr++;
            end
            // Flush empties the ring and the commit pointer catches up with the issue pointer
            FLUSH: begin
                m_busy = '0;
                m_cptr = m_iptr;
            end
            default: ;
        endcase
        decoded_instr_valid_i = 1'b0;
        flush_unissued_instr_i = 1'b0;
        flush_i = 1'b0;
        lsu_ready_i = 1'b1;
        wt_valid_i = 1'b0;
        commit_ack_i = 1'b0;
        we_i = 1'b0;
        $display("row %0d %s: %s", n, r.act.name(), (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        flush_unissued_instr_i = 1'b0;
        decoded_instr_i = '0;
        decoded_instr_valid_i = 1'b0;
        alu_ready_i = 1'b1;
        lsu_ready_i = 1'b1;
        wt_valid_i = 1'b0;
        trans_id_i = '0;
        wbdata_i = '0;
        commit_ack_i = 1'b0;
        we_i = 1'b0;
        waddr_i = '0;
        wdata_i = '0;
        foreach (m_regs[i]) m_regs[i] = '0;
        m_busy = '0;
        m_iptr = '0;
        m_cptr = '0;

        // --------------------------------------
        // Register setup, operands, hazard and forwarding
        add_row(WRITE_REG, issue_pkg::FU_NONE, 1, 0, 0, 0, 0, 0);
        add_row(WRITE_REG, issue_pkg::FU_NONE, 2, 0, 0, 0, 0, 0);
        add_row(WRITE_REG, issue_pkg::FU_NONE, 3, 0, 0, 0, 0, 0);
        add_row(WRITE_REG, issue_pkg::FU_NONE, 5, 0, 0, 0, 0, 0);
        add_row(WRITE_REG, issue_pkg::FU_NONE, 10, 0, 0, 0, 0, 0);
        add_row(ISSUE, issue_pkg::FU_ALU, 5, 1, 2, 0, 1, 1);
        add_row(ISSUE, issue_pkg::FU_ALU, 6, 3, 0, 32'h55, 1, 1);
        add_row(ISSUE, issue_pkg::FU_ALU, 7, 5, 2, 0, 0, 1);
        add_row(WRITEBACK, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        add_row(ISSUE, issue_pkg::FU_ALU, 7, 5, 2, 0, 1, 1);
        // Back-pressure, then a full ring
        add_row(ISSUE, issue_pkg::FU_LSU, 8, 1, 3, 0, 0, 0);
        add_row(ISSUE, issue_pkg::FU_ALU, 9, 2, 3, 0, 1, 0);
        add_row(ISSUE, issue_pkg::FU_ALU, 11, 1, 1, 0, 0, 1);
        // In-order commit with writebacks in reverse order
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 1, 0);
        add_row(WRITEBACK, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 3);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        add_row(WRITEBACK, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 2);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        add_row(WRITEBACK, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 1);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 1, 0);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 1, 0);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 1, 0);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        // Flush with two in flight and the oldest finished, then issue after it
        add_row(ISSUE, issue_pkg::FU_ALU, 10, 1, 0, 0, 1, 1);
        add_row(ISSUE, issue_pkg::FU_LSU, 10, 2, 3, 0, 1, 1);
        add_row(WRITEBACK, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        add_row(FLUSH, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        add_row(ISSUE_FLUSHED, issue_pkg::FU_ALU, 12, 10, 5, 0, 0, 1);
        add_row(ISSUE, issue_pkg::FU_ALU, 12, 10, 5, 0, 1, 1);
        add_row(COMMIT, issue_pkg::FU_NONE, 0, 0, 0, 0, 0, 0);
        limit = rows.size() * 10 + 100;

        repeat (3) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        #5;
        check_equal("ack after reset", decoded_instr_ack_o, 0);
        check_equal("alu_valid_o after reset", alu_valid_o, 0);
        check_equal("lsu_valid_o after reset", lsu_valid_o, 0);
        check_equal("commit_valid_o after reset", commit_valid_o, 0);
        check_equal("sb_full_o after reset", sb_full_o, 0);
        $display("reset: %s", (errors == 0) ? "ok" : "mismatch");

        foreach (rows[i]) apply_row(i);

        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/issue_pkg.sv
rtl/sb_iro_if.sv
rtl/scoreboard.sv
rtl/regfile.sv
rtl/issue_read_operands.sv
rtl/issue_stage.sv
verif/issue_stage_tb.sv
